// ==== hw/csr_macros.svh ====
////////////////////
// CSR subsystem constants
// widths, CSR addresses, operation codes
// and buffer sizes for the CSR block
////////////////////

`ifndef CSR_MACROS_SVH
`define CSR_MACROS_SVH

// datapath and id widths
`define CSR_ADDR_W      12
`define CSR_DATA_W      32
`define NUM_WARPS       4
`define WARP_ID_W       2
`define REG_ID_W        5
`define IRQ_LINES       8

// operation codes
`define CSR_OP_RW       2'd0
`define CSR_OP_RS       2'd1
`define CSR_OP_RC       2'd2

// local CSR addresses
`define CSR_MSCRATCH    12'h340
`define CSR_MCYCLE      12'hB00
`define CSR_MINSTRET    12'hB02
`define CSR_MHARTID     12'hF14

// interrupt controller window, end is exclusive
`define CSR_IRQ_ENABLE  12'h7C0
`define CSR_IRQ_PENDING 12'h7C1
`define CSR_IRQ_BEGIN   12'h7C0
`define CSR_IRQ_END     12'h7C2

`define RSP_BUF_DEPTH   2

`endif

// ==== hw/csr_pkg.sv ====
////////////////////
// CSR subsystem types
// vector typedefs shared by the CSR
// unit, its register blocks and the
// testbench
////////////////////

`include "csr_macros.svh"

package csr_pkg;

    // CSR address as decoded by the unit
    typedef logic [`CSR_ADDR_W-1:0] csr_addr_t;

    // value read from or written to a CSR
    typedef logic [`CSR_DATA_W-1:0] csr_data_t;

    // warp index, selects the per-warp scratch
    typedef logic [`WARP_ID_W-1:0] warp_id_t;

    // destination register carried back with the response
    typedef logic [`REG_ID_W-1:0] reg_id_t;

    // rw / rs / rc selector
    typedef logic [1:0] csr_op_t;

    // one bit per external interrupt line
    typedef logic [`IRQ_LINES-1:0] irq_mask_t;

endpackage

// ==== hw/csr_rsp_buffer.sv ====
////////////////////
// csr_rsp_buffer
// small in-order FIFO for CSR responses,
// absorbs back-pressure on the commit side
////////////////////

`timescale 1ns/1ps

`include "csr_macros.svh"

module csr_rsp_buffer import csr_pkg::*; (
    input  logic      clk,
    input  logic      reset,

    input  logic      in_valid,
    output logic      in_ready,
    input  csr_data_t in_data,
    input  warp_id_t  in_wid,
    input  reg_id_t   in_rd,

    output logic      out_valid,
    input  logic      out_ready,
    output csr_data_t out_data,
    output warp_id_t  out_wid,
    output reg_id_t   out_rd
);

    localparam int DEPTH = `RSP_BUF_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    csr_data_t        data_q [DEPTH];
    warp_id_t         wid_q  [DEPTH];
    reg_id_t          rd_q   [DEPTH];

    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             push;
    logic             pop;

    assign in_ready  = (count_q != CNT_W'(DEPTH));
    assign out_valid = (count_q != '0);
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    assign out_data = data_q[rd_ptr_q];
    assign out_wid  = wid_q[rd_ptr_q];
    assign out_rd   = rd_q[rd_ptr_q];

    // payload slots, no reset needed
    always_ff @(posedge clk) begin
        if (push) begin
            data_q[wr_ptr_q] <= in_data;
            wid_q[wr_ptr_q]  <= in_wid;
            rd_q[wr_ptr_q]   <= in_rd;
        end
    end

    // push and pop may share a cycle, count holds then
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            if (push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

endmodule

// ==== hw/csr_file.sv ====
////////////////////
// csr_file
// core-local CSRs: per-warp scratch,
// cycle and retired counters, hart id
// combinational read, write at the edge
////////////////////

`timescale 1ns/1ps

`include "csr_macros.svh"

module csr_file import csr_pkg::*; #(
    parameter int CORE_ID = 0
) (
    input  logic      clk,
    input  logic      reset,

    // read port, answered in the same cycle
    input  csr_addr_t rd_addr,
    input  warp_id_t  rd_wid,
    output csr_data_t rd_data,
    output logic      rd_hit,

    // write port
    input  logic      wr_en,
    input  csr_addr_t wr_addr,
    input  warp_id_t  wr_wid,
    input  csr_data_t wr_data,

    // one pulse per accepted CSR request
    input  logic      retire
);

    csr_data_t scratch_q [`NUM_WARPS];
    csr_data_t mcycle_q;
    csr_data_t minstret_q;
    csr_data_t hart_id;

    logic      wr_scratch;
    logic      wr_mcycle;
    logic      wr_minstret;

    // global hart index, one hart per warp
    assign hart_id = csr_data_t'(CORE_ID * `NUM_WARPS) + csr_data_t'(rd_wid);

    assign wr_scratch  = wr_en && (wr_addr == `CSR_MSCRATCH);
    assign wr_mcycle   = wr_en && (wr_addr == `CSR_MCYCLE);
    assign wr_minstret = wr_en && (wr_addr == `CSR_MINSTRET);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `NUM_WARPS; i++) begin
                scratch_q[i] <= '0;
            end
        end else if (wr_scratch) begin
            scratch_q[wr_wid] <= wr_data;
        end
    end

    // free running, a write loads a new start value
    always_ff @(posedge clk) begin
        if (reset) begin
            mcycle_q <= '0;
        end else if (wr_mcycle) begin
            mcycle_q <= wr_data;
        end else begin
            mcycle_q <= mcycle_q + 1'b1;
        end
    end

    // an explicit write takes priority over the retire increment
    always_ff @(posedge clk) begin
        if (reset) begin
            minstret_q <= '0;
        end else if (wr_minstret) begin
            minstret_q <= wr_data;
        end else if (retire) begin
            minstret_q <= minstret_q + 1'b1;
        end
    end

    // mhartid has no write path, so writes to it fall through
    always_comb begin
        rd_data = '0;
        rd_hit  = 1'b1;
        case (rd_addr)
            `CSR_MSCRATCH: rd_data = scratch_q[rd_wid];
            `CSR_MCYCLE:   rd_data = mcycle_q;
            `CSR_MINSTRET: rd_data = minstret_q;
            `CSR_MHARTID:  rd_data = hart_id;
            default:       rd_hit  = 1'b0;
        endcase
    end

endmodule

// ==== hw/irq_ctrl_csr.sv ====
////////////////////
// irq_ctrl_csr
// interrupt controller CSRs: enable mask
// and sticky pending bits from external
// lines, registered interrupt output
////////////////////

`timescale 1ns/1ps

`include "csr_macros.svh"

module irq_ctrl_csr import csr_pkg::*; (
    input  logic      clk,
    input  logic      reset,

    // read port, combinational
    input  csr_addr_t rd_addr,
    output csr_data_t rd_data,

    // write port
    input  logic      wr_en,
    input  csr_addr_t wr_addr,
    input  csr_data_t wr_data,

    // external lines in, request to the core out
    input  irq_mask_t irq_lines,
    output logic      irq_out
);

    irq_mask_t enable_q;
    irq_mask_t pending_q;
    irq_mask_t pending_next;

    logic      wr_enable;
    logic      wr_pending;

    assign wr_enable  = wr_en && (wr_addr == `CSR_IRQ_ENABLE);
    assign wr_pending = wr_en && (wr_addr == `CSR_IRQ_PENDING);

    // a write can only drop a bit whose line is low this cycle
    always_comb begin
        if (wr_pending) begin
            pending_next = wr_data[`IRQ_LINES-1:0] | irq_lines;
        end else begin
            pending_next = pending_q | irq_lines;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            enable_q <= '0;
        end else if (wr_enable) begin
            enable_q <= wr_data[`IRQ_LINES-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pending_q <= '0;
        end else begin
            pending_q <= pending_next;
        end
    end

    // one cycle behind a change of pending or enable
    always_ff @(posedge clk) begin
        if (reset) begin
            irq_out <= 1'b0;
        end else begin
            irq_out <= |(pending_q & enable_q);
        end
    end

    always_comb begin
        case (rd_addr)
            `CSR_IRQ_ENABLE:  rd_data = csr_data_t'(enable_q);
            `CSR_IRQ_PENDING: rd_data = csr_data_t'(pending_q);
            default:          rd_data = '0;
        endcase
    end

endmodule

// ==== hw/csr_unit.sv ====
////////////////////
// csr_unit
// CSR execute stage: address decode,
// old value select, read-modify-write
// and buffered response to commit
////////////////////

`timescale 1ns/1ps

`include "csr_macros.svh"

module csr_unit import csr_pkg::*; #(
    parameter int CORE_ID = 0
) (
    input  logic      clk,
    input  logic      reset,

    // execute request
    input  logic      req_valid,
    output logic      req_ready,
    input  csr_op_t   req_op,
    input  csr_addr_t req_addr,
    input  logic      req_use_imm,
    input  logic [4:0] req_imm,
    input  csr_data_t req_rs1,
    input  warp_id_t  req_wid,
    input  reg_id_t   req_rd,

    // commit response
    output logic      rsp_valid,
    input  logic      rsp_ready,
    output csr_data_t rsp_data,
    output warp_id_t  rsp_wid,
    output reg_id_t   rsp_rd,

    // core-local CSR file
    output csr_addr_t file_rd_addr,
    output warp_id_t  file_rd_wid,
    input  csr_data_t file_rd_data,
    input  logic      file_rd_hit,
    output logic      file_wr_en,
    output csr_addr_t file_wr_addr,
    output warp_id_t  file_wr_wid,
    output csr_data_t file_wr_data,
    output logic      retire,

    // interrupt controller CSRs
    output csr_addr_t irq_rd_addr,
    input  csr_data_t irq_rd_data,
    output logic      irq_wr_en,
    output csr_addr_t irq_wr_addr,
    output csr_data_t irq_wr_data
);

    logic      req_fire;
    logic      irq_addr_hit;
    logic      read_only;
    logic      wr_allowed;
    csr_data_t src_data;
    csr_data_t old_data;
    csr_data_t new_data;

    // hart ids are built from a non-negative core index
    if (CORE_ID < 0) begin : g_core_id_check
        $error("csr_unit: CORE_ID must be non-negative");
    end

    assign req_fire     = req_valid && req_ready;
    assign irq_addr_hit = (req_addr >= `CSR_IRQ_BEGIN) && (req_addr < `CSR_IRQ_END);
    // standard encoding, top two address bits set means read-only
    assign read_only    = (req_addr[`CSR_ADDR_W-1 -: 2] == 2'b11);

    assign src_data = req_use_imm ? csr_data_t'(req_imm) : req_rs1;

    // unknown addresses read as zero
    assign old_data = irq_addr_hit ? irq_rd_data :
                      file_rd_hit  ? file_rd_data : '0;

    always_comb begin
        case (req_op)
            `CSR_OP_RW: new_data = src_data;
            `CSR_OP_RS: new_data = old_data | src_data;
            `CSR_OP_RC: new_data = old_data & ~src_data;
            default:    new_data = old_data;
        endcase
    end

    // rs/rc with a zero source is a pure read
    assign wr_allowed = (req_op == `CSR_OP_RW) || (src_data != '0);

    assign file_rd_addr = req_addr;
    assign file_rd_wid  = req_wid;
    assign file_wr_en   = req_fire && wr_allowed && !irq_addr_hit && file_rd_hit && !read_only;
    assign file_wr_addr = req_addr;
    assign file_wr_wid  = req_wid;
    assign file_wr_data = new_data;
    assign retire       = req_fire;

    assign irq_rd_addr = req_addr;
    assign irq_wr_en   = req_fire && wr_allowed && irq_addr_hit;
    assign irq_wr_addr = req_addr;
    assign irq_wr_data = new_data;

    // old value goes back, ready follows buffer space
    csr_rsp_buffer rsp_buf_i (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (req_valid),
        .in_ready  (req_ready),
        .in_data   (old_data),
        .in_wid    (req_wid),
        .in_rd     (req_rd),
        .out_valid (rsp_valid),
        .out_ready (rsp_ready),
        .out_data  (rsp_data),
        .out_wid   (rsp_wid),
        .out_rd    (rsp_rd)
    );

endmodule

// ==== hw/csr_subsys_top.sv ====
////////////////////
// csr_subsys_top
// CSR unit with its local CSR file and
// interrupt controller CSR block
////////////////////

`timescale 1ns/1ps

module csr_subsys_top import csr_pkg::*; #(
    parameter int CORE_ID = 0
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       req_valid,
    output logic       req_ready,
    input  csr_op_t    req_op,
    input  csr_addr_t  req_addr,
    input  logic       req_use_imm,
    input  logic [4:0] req_imm,
    input  csr_data_t  req_rs1,
    input  warp_id_t   req_wid,
    input  reg_id_t    req_rd,
    output logic       rsp_valid,
    input  logic       rsp_ready,
    output csr_data_t  rsp_data,
    output warp_id_t   rsp_wid,
    output reg_id_t    rsp_rd,
    input  irq_mask_t  irq_lines,
    output logic       irq_out
);

    csr_addr_t file_rd_addr;
    warp_id_t  file_rd_wid;
    csr_data_t file_rd_data;
    logic      file_rd_hit;
    logic      file_wr_en;
    csr_addr_t file_wr_addr;
    warp_id_t  file_wr_wid;
    csr_data_t file_wr_data;
    logic      retire;
    csr_addr_t irq_rd_addr;
    csr_data_t irq_rd_data;
    logic      irq_wr_en;
    csr_addr_t irq_wr_addr;
    csr_data_t irq_wr_data;

    csr_unit #(
        .CORE_ID (CORE_ID)
    ) csr_unit_i (
        .clk          (clk),
        .reset        (reset),
        .req_valid    (req_valid),
        .req_ready    (req_ready),
        .req_op       (req_op),
        .req_addr     (req_addr),
        .req_use_imm  (req_use_imm),
        .req_imm      (req_imm),
        .req_rs1      (req_rs1),
        .req_wid      (req_wid),
        .req_rd       (req_rd),
        .rsp_valid    (rsp_valid),
        .rsp_ready    (rsp_ready),
        .rsp_data     (rsp_data),
        .rsp_wid      (rsp_wid),
        .rsp_rd       (rsp_rd),
        .file_rd_addr (file_rd_addr),
        .file_rd_wid  (file_rd_wid),
        .file_rd_data (file_rd_data),
        .file_rd_hit  (file_rd_hit),
        .file_wr_en   (file_wr_en),
        .file_wr_addr (file_wr_addr),
        .file_wr_wid  (file_wr_wid),
        .file_wr_data (file_wr_data),
        .retire       (retire),
        .irq_rd_addr  (irq_rd_addr),
        .irq_rd_data  (irq_rd_data),
        .irq_wr_en    (irq_wr_en),
        .irq_wr_addr  (irq_wr_addr),
        .irq_wr_data  (irq_wr_data)
    );

    csr_file #(
        .CORE_ID (CORE_ID)
    ) csr_file_i (
        .clk     (clk),
        .reset   (reset),
        .rd_addr (file_rd_addr),
        .rd_wid  (file_rd_wid),
        .rd_data (file_rd_data),
        .rd_hit  (file_rd_hit),
        .wr_en   (file_wr_en),
        .wr_addr (file_wr_addr),
        .wr_wid  (file_wr_wid),
        .wr_data (file_wr_data),
        .retire  (retire)
    );

    irq_ctrl_csr irq_ctrl_csr_i (
        .clk       (clk),
        .reset     (reset),
        .rd_addr   (irq_rd_addr),
        .rd_data   (irq_rd_data),
        .wr_en     (irq_wr_en),
        .wr_addr   (irq_wr_addr),
        .wr_data   (irq_wr_data),
        .irq_lines (irq_lines),
        .irq_out   (irq_out)
    );

endmodule

// ==== dv/csr_subsys_asserts.sv ====
////////////////////
// csr_subsys_asserts
// handshake and response buffer checks,
// bound into the CSR unit
////////////////////

`timescale 1ns/1ps

module csr_subsys_asserts import csr_pkg::*; (
    input logic      clk,
    input logic      reset,
    input logic      req_valid,
    input logic      req_ready,
    input logic      rsp_valid,
    input logic      rsp_ready,
    input csr_data_t rsp_data,
    input reg_id_t   rsp_rd
);

    // a stalled response keeps its payload
    assert property (@(posedge clk) disable iff (reset)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_data) && $stable(rsp_rd))
        else $error("response changed while stalled");

    // a drained slot reopens the request side
    assert property (@(posedge clk) disable iff (reset)
        rsp_valid && rsp_ready |=> req_ready)
        else $error("req_ready low after a response was taken");

    // after reset the unit is idle and ready
    assert property (@(posedge clk) $fell(reset) |-> req_ready && !rsp_valid)
        else $error("unit not idle after reset");

endmodule

bind csr_unit csr_subsys_asserts csr_asserts_i (.*);

// ==== dv/csr_subsys_tb.sv ====
////////////////////
// csr_subsys_tb
// table driven test of the CSR subsystem
// against a shadow register model
////////////////////

`timescale 1ns/1ps

`include "csr_macros.svh"

module csr_subsys_tb import csr_pkg::*;;

    localparam int TB_CORE_ID = 1;
    localparam int MAX_ENTRIES = 32;
    localparam int TIMEOUT_CYCLES = 50;

    logic clk = 1'b0;
    logic reset;
    logic req_valid;
    logic req_ready;
    logic req_use_imm;
    logic rsp_valid;
    logic rsp_ready;
    logic irq_out;
    csr_op_t req_op;
    csr_addr_t req_addr;
    logic [4:0] req_imm;
    csr_data_t req_rs1;
    csr_data_t rsp_data;
    warp_id_t req_wid;
    warp_id_t rsp_wid;
    reg_id_t req_rd;
    reg_id_t rsp_rd;
    irq_mask_t irq_lines;

    // stimulus table columns
    // kind 0 checks the model, 1 the table value, 2 a rising mcycle
    csr_op_t t_op [MAX_ENTRIES];
    csr_addr_t t_addr [MAX_ENTRIES];
    logic t_use_imm [MAX_ENTRIES];
    logic [4:0] t_imm [MAX_ENTRIES];
    csr_data_t t_rs1 [MAX_ENTRIES];
    warp_id_t t_wid [MAX_ENTRIES];
    reg_id_t t_rd [MAX_ENTRIES];
    logic t_stall [MAX_ENTRIES];
    csr_data_t t_exp [MAX_ENTRIES];
    int t_kind [MAX_ENTRIES];
    irq_mask_t t_pulse [MAX_ENTRIES];
    int t_irq_exp [MAX_ENTRIES];
    int num_entries = 0;
    logic table_ready = 1'b0;

    // shadow model
    csr_data_t m_scratch [`NUM_WARPS];
    irq_mask_t m_enable;
    irq_mask_t m_pending;
    csr_data_t m_minstret;
    csr_data_t last_mcycle;

    int errors = 0;
    int timeouts = 0;
    int seed = 90;
    csr_data_t exp_q [$];
    warp_id_t exp_wid_q [$];
    reg_id_t exp_rd_q [$];

    csr_subsys_top #(.CORE_ID(TB_CORE_ID)) csr_subsys_top_i (.*);

    always #5 clk = ~clk;

    task automatic add_entry(input csr_op_t op, input csr_addr_t addr, input logic use_imm,
                             input logic [4:0] imm, input csr_data_t rs1, input warp_id_t wid,
                             input reg_id_t rd, input logic stall, input int kind,
                             input csr_data_t exp, input irq_mask_t pulse, input int irq_exp);
        t_op[num_entries] = op;
        t_addr[num_entries] = addr;
        t_use_imm[num_entries] = use_imm;
        t_imm[num_entries] = imm;
        t_rs1[num_entries] = rs1;
        t_wid[num_entries] = wid;
        t_rd[num_entries] = rd;
        t_stall[num_entries] = stall;
        t_kind[num_entries] = kind;
        t_exp[num_entries] = exp;
        t_pulse[num_entries] = pulse;
        t_irq_exp[num_entries] = irq_exp;
        num_entries++;
    endtask

    function automatic csr_data_t model_read(input csr_addr_t addr, input warp_id_t wid);
        case (addr)
            `CSR_MSCRATCH: return m_scratch[wid];
            `CSR_MINSTRET: return m_minstret;
            `CSR_MHARTID: return csr_data_t'(TB_CORE_ID * 4 + int'(wid));
            `CSR_IRQ_ENABLE: return csr_data_t'(m_enable);
            `CSR_IRQ_PENDING: return csr_data_t'(m_pending);
            default: return '0;
        endcase
    endfunction

    // set/clear/write rule followed by the retired count
    task automatic model_apply(input csr_op_t op, input csr_addr_t addr, input logic use_imm,
                               input logic [4:0] imm, input csr_data_t rs1,
                               input warp_id_t wid);
        csr_data_t src;
        csr_data_t old;
        csr_data_t nval;
        src = use_imm ? {27'd0, imm} : rs1;
        old = model_read(addr, wid);
        nval = (op == `CSR_OP_RW) ? src : (op == `CSR_OP_RS) ? (old | src) : (old & ~src);
        if (op == `CSR_OP_RW || src != '0) begin
            if (addr == `CSR_MSCRATCH) m_scratch[wid] = nval;
            if (addr == `CSR_IRQ_ENABLE) m_enable = nval[`IRQ_LINES-1:0];
            if (addr == `CSR_IRQ_PENDING) m_pending = nval[`IRQ_LINES-1:0];
        end
        m_minstret = m_minstret + 1;
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // drives one request and returns after its acceptance edge
    task automatic issue(input int i);
        int waited;
        req_valid = 1'b1;
        req_op = t_op[i];
        req_addr = t_addr[i];
        req_use_imm = t_use_imm[i];
        req_imm = t_imm[i];
        req_rs1 = t_rs1[i];
        req_wid = t_wid[i];
        req_rd = t_rd[i];
        waited = 0;
        while (!req_ready && waited < TIMEOUT_CYCLES) begin
            next_cycle();
            waited++;
        end
        if (!req_ready) begin
            $display("request %0d was never accepted", i);
            timeouts++;
        end
        exp_q.push_back(t_kind[i] == 1 ? t_exp[i] : model_read(t_addr[i], t_wid[i]));
        exp_wid_q.push_back(t_wid[i]);
        exp_rd_q.push_back(t_rd[i]);
        model_apply(t_op[i], t_addr[i], t_use_imm[i], t_imm[i], t_rs1[i], t_wid[i]);
        next_cycle();
        req_valid = 1'b0;
    endtask

    task automatic check_response(input int i);
        csr_data_t exp;
        warp_id_t wid;
        reg_id_t rd;
        exp = exp_q.pop_front();
        wid = exp_wid_q.pop_front();
        rd = exp_rd_q.pop_front();
        if (!rsp_valid) begin
            $display("CHECK FAILED at %0t: entry %0d has no response", $time, i);
            errors++;
        end
        if (t_kind[i] == 2) begin
            if (rsp_data <= last_mcycle) begin
                $display("CHECK FAILED at %0t: mcycle %0d not above %0d", $time,
                         rsp_data, last_mcycle);
                errors++;
            end
            last_mcycle = rsp_data;
        end else if (rsp_data != exp) begin
            $display("CHECK FAILED at %0t: entry %0d data %h expected %h", $time, i,
                     rsp_data, exp);
            errors++;
        end
        if (rsp_wid != wid || rsp_rd != rd) begin
            $display("CHECK FAILED at %0t: entry %0d wid/rd %0d/%0d expected %0d/%0d",
                     $time, i, rsp_wid, rsp_rd, wid, rd);
            errors++;
        end
    endtask

    initial begin
        wait (table_ready);
        repeat (num_entries * 20 + 200) @(posedge clk);
        $display("watchdog expired, the test did not finish in time");
        $display("TB FAILED");
        $finish;
    end

    initial begin
        int stall_cycles;
        reset = 1'b1;
        req_valid = 1'b0;
        req_op = '0;
        req_addr = '0;
        req_use_imm = 1'b0;
        req_imm = '0;
        req_rs1 = '0;
        req_wid = '0;
        req_rd = '0;
        rsp_ready = 1'b1;
        irq_lines = '0;
        for (int w = 0; w < `NUM_WARPS; w++) m_scratch[w] = '0;
        m_enable = '0;
        m_pending = '0;
        m_minstret = '0;
        last_mcycle = '0;

        // op, addr, imm?, imm, rs1, wid, rd, stall, kind, exp, pulse, irq_out
        add_entry(`CSR_OP_RW, `CSR_MSCRATCH, 0, 0, 32'h1234_5678, 0, 1, 0, 0, 0, 0, 2);
        add_entry(`CSR_OP_RS, `CSR_MSCRATCH, 0, 0, 32'h0000_00F0, 0, 2, 0, 0, 0, 0, 2);
        add_entry(`CSR_OP_RC, `CSR_MSCRATCH, 1, 5'h08, 0, 0, 3, 1, 0, 0, 0, 2);
        add_entry(`CSR_OP_RW, `CSR_MSCRATCH, 1, 5'h1F, 0, 2, 4, 0, 0, 0, 0, 2);
        add_entry(`CSR_OP_RS, `CSR_MSCRATCH, 0, 0, 32'h0, 0, 5, 0, 0, 0, 0, 2);
        add_entry(`CSR_OP_RC, `CSR_MSCRATCH, 1, 5'h00, 0, 2, 6, 0, 0, 0, 0, 2);
        add_entry(`CSR_OP_RS, `CSR_MSCRATCH, 0, 0, 32'h0, 2, 7, 1, 0, 0, 0, 2);
        add_entry(`CSR_OP_RW, `CSR_MHARTID, 0, 0, 32'h55, 1, 8, 0, 1, 32'd5, 0, 2);
        add_entry(`CSR_OP_RS, `CSR_MHARTID, 0, 0, 32'h0, 3, 9, 0, 1, 32'd7, 0, 2);
        add_entry(`CSR_OP_RW, 12'h123, 0, 0, 32'hFFFF_FFFF, 0, 10, 0, 0, 0, 0, 2);
        add_entry(`CSR_OP_RS, 12'h123, 0, 0, 32'h0, 0, 11, 0, 0, 0, 0, 2);
        add_entry(`CSR_OP_RS, `CSR_MINSTRET, 0, 0, 32'h0, 1, 12, 0, 0, 0, 0, 2);
        add_entry(`CSR_OP_RS, `CSR_MINSTRET, 0, 0, 32'h0, 1, 13, 1, 0, 0, 0, 2);
        add_entry(`CSR_OP_RS, `CSR_MCYCLE, 0, 0, 32'h0, 0, 14, 0, 2, 0, 0, 2);
        add_entry(`CSR_OP_RS, `CSR_MCYCLE, 0, 0, 32'h0, 0, 15, 1, 2, 0, 0, 2);
        add_entry(`CSR_OP_RS, `CSR_IRQ_PENDING, 0, 0, 32'h0, 0, 16, 0, 0, 0, 8'h05, 0);
        add_entry(`CSR_OP_RW, `CSR_IRQ_ENABLE, 0, 0, 32'h05, 0, 17, 0, 0, 0, 0, 1);
        add_entry(`CSR_OP_RC, `CSR_IRQ_PENDING, 1, 5'h05, 0, 0, 18, 0, 0, 0, 0, 0);
        add_entry(`CSR_OP_RS, `CSR_IRQ_PENDING, 0, 0, 32'h0, 0, 19, 1, 0, 0, 0, 0);
        add_entry(`CSR_OP_RS, `CSR_MSCRATCH, 0, 0, 32'h0, 0, 31, 1, 0, 0, 0, 2);
        // back-pressure group of pure reads in three warps
        add_entry(`CSR_OP_RS, `CSR_MSCRATCH, 0, 0, 32'h0, 0, 20, 0, 0, 0, 0, 2);
        add_entry(`CSR_OP_RS, `CSR_MSCRATCH, 0, 0, 32'h0, 2, 21, 0, 0, 0, 0, 2);
        add_entry(`CSR_OP_RS, `CSR_MHARTID, 0, 0, 32'h0, 3, 22, 0, 0, 0, 0, 2);
        table_ready = 1'b1;

        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        next_cycle();

        for (int i = 0; i < num_entries - 3; i++) begin
            if (t_pulse[i] != '0) begin
                irq_lines = t_pulse[i];
                m_pending = m_pending | t_pulse[i];
                next_cycle();
                irq_lines = '0;
            end
            issue(i);
            if (t_stall[i]) begin
                rsp_ready = 1'b0;
                stall_cycles = 1 + ($unsigned($random(seed)) % 4);
                repeat (stall_cycles) next_cycle();
                rsp_ready = 1'b1;
            end
            check_response(i);
            next_cycle();
            if (rsp_valid) begin
                $display("CHECK FAILED at %0t: extra response after entry %0d", $time, i);
                errors++;
            end
            if (t_irq_exp[i] != 2 && irq_out != t_irq_exp[i][0]) begin
                $display("CHECK FAILED at %0t: irq_out %b expected %0d", $time, irq_out,
                         t_irq_exp[i]);
                errors++;
            end
        end

        // buffer fills after two responses and then drains in order
        rsp_ready = 1'b0;
        issue(num_entries - 3);
        issue(num_entries - 2);
        if (req_ready) begin
            $display("CHECK FAILED at %0t: req_ready high with a full buffer", $time);
            errors++;
        end
        rsp_ready = 1'b1;
        check_response(num_entries - 3);
        next_cycle();
        check_response(num_entries - 2);
        issue(num_entries - 1);
        check_response(num_entries - 1);
        next_cycle();

        $display("checks done: %0d errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== csr_core.f ====
+incdir+hw
hw/csr_pkg.sv
hw/csr_rsp_buffer.sv
hw/csr_file.sv
hw/irq_ctrl_csr.sv
hw/csr_unit.sv
hw/csr_subsys_top.sv
dv/csr_subsys_asserts.sv
dv/csr_subsys_tb.sv

// ==== run_sim.sh ====
#!/bin/bash
# build and run the CSR subsystem testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wall -Wno-fatal \
    --top-module csr_subsys_tb \
    -f csr_core.f

sim_out=$(./obj_dir/Vcsr_subsys_tb || true)
echo "$sim_out"

if echo "$sim_out" | grep -qx "TB PASSED"; then
    exit 0
else
    exit 1
fi
